// File: rtl/mem_pkg.sv
// Widths, opcode and funct3 encodings and sequencer states shared by the memory stage
`default_nettype none

package mem_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int XLEN       = 32;
    localparam int BYTE_W     = 8;
    localparam int REG_ADDR_W = 5;
    localparam int BYTE_IDX_W = 2;

    ////////////////////////////////////////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////////////////////////////////////////

    // RV32 major opcodes
    typedef enum logic [6:0] {
        OP_NOP   = 7'b0000000,
        OP_LOAD  = 7'b0000011,
        OP_STORE = 7'b0100011,
        OP_IMM   = 7'b0010011,
        OP_REG   = 7'b0110011
    } opcode_e;

    // funct3 for loads and stores
    typedef enum logic [2:0] {
        F_B  = 3'b000,
        F_H  = 3'b001,
        F_W  = 3'b010,
        F_BU = 3'b100,
        F_HU = 3'b101
    } mem_funct_e;

    // Byte port command
    typedef enum logic [1:0] {
        RW_IDLE  = 2'b00,
        RW_READ  = 2'b01,
        RW_WRITE = 2'b10
    } mem_rw_e;

    typedef enum logic [1:0] {
        S_IDLE,
        S_ACCESS,
        S_DRAIN,
        S_DONE
    } seq_state_e;

endpackage

`default_nettype wire

// File: rtl/mem_byte_if.sv
// Byte capture controls passed from the byte sequencer to the load assembler
`timescale 1ns/1ps
`default_nettype none

interface mem_byte_if;
    import mem_pkg::*;

    logic                  clear;
    logic                  capture;
    logic [BYTE_IDX_W-1:0] byte_idx;
    // Index of the last byte of the access
    logic [BYTE_IDX_W-1:0] width;
    logic                  is_unsigned;

    modport seq (
        output clear, capture, byte_idx, width, is_unsigned
    );

    modport load (
        input clear, capture, byte_idx, width, is_unsigned
    );

endinterface

`default_nettype wire

// File: rtl/load_unit.sv
// Load assembler that gathers returned bytes little-endian and extends the result
`timescale 1ns/1ps
`default_nettype none

module load_unit (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic [mem_pkg::BYTE_W-1:0] mem_rdata_i,
    mem_byte_if.load                   bif,
    output logic [mem_pkg::XLEN-1:0]   load_data_o
);
    import mem_pkg::*;

    logic [XLEN-1:0] word_q;
    logic            sign_b;
    logic            sign_h;

    // Byte lanes
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            word_q <= '0;
        end else if (bif.clear) begin
            word_q <= '0;
        end else if (bif.capture) begin
            word_q[{bif.byte_idx, 3'b000} +: BYTE_W] <= mem_rdata_i;
        end
    end

    assign sign_b = !bif.is_unsigned && word_q[BYTE_W-1];
    assign sign_h = !bif.is_unsigned && word_q[2*BYTE_W-1];

    // Sign or zero extension
    always_comb begin
        case (bif.width)
            BYTE_IDX_W'(0): begin
                load_data_o = {{(XLEN-BYTE_W){sign_b}}, word_q[BYTE_W-1:0]};
            end
            BYTE_IDX_W'(1): begin
                load_data_o = {{(XLEN-2*BYTE_W){sign_h}}, word_q[2*BYTE_W-1:0]};
            end
            default: begin
                load_data_o = word_q;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/mem_byte_seq.sv
// Byte sequencer that walks an access over the byte memory port and flags completion
`timescale 1ns/1ps
`default_nettype none

module mem_byte_seq (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      start_i,
    input  logic                      is_store_i,
    input  mem_pkg::mem_funct_e       funct_i,
    input  logic [mem_pkg::XLEN-1:0]  base_addr_i,
    input  logic [mem_pkg::XLEN-1:0]  store_data_i,
    output mem_pkg::mem_rw_e          mem_rw_o,
    output logic [mem_pkg::XLEN-1:0]  mem_addr_o,
    output logic [mem_pkg::BYTE_W-1:0] mem_wdata_o,
    output logic                      done_o,
    mem_byte_if.seq                   bif
);
    import mem_pkg::*;

    seq_state_e            state_q;
    seq_state_e            state_d;
    logic [BYTE_IDX_W-1:0] cnt_q;
    logic [BYTE_IDX_W-1:0] last_idx;
    logic                  is_unsigned;

    ////////////////////////////////////////////////////////////////////////////
    // Access width decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (funct_i)
            F_B, F_BU: last_idx = BYTE_IDX_W'(0);
            F_H, F_HU: last_idx = BYTE_IDX_W'(1);
            default:   last_idx = BYTE_IDX_W'(3);
        endcase
    end

    assign is_unsigned = (funct_i == F_BU) || (funct_i == F_HU);

    ////////////////////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (start_i) begin
                    state_d = S_ACCESS;
                end
            end
            S_ACCESS: begin
                // Last byte goes out this cycle
                if (cnt_q == last_idx) begin
                    state_d = S_DRAIN;
                end
            end
            S_DRAIN: begin
                state_d = S_DONE;
            end
            default: begin
                state_d = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= S_IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == S_ACCESS) begin
                cnt_q <= cnt_q + BYTE_IDX_W'(1);
            end else if (state_q == S_IDLE) begin
                cnt_q <= '0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Memory port
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        mem_rw_o    = RW_IDLE;
        mem_wdata_o = '0;
        if (state_q == S_ACCESS) begin
            if (is_store_i) begin
                mem_rw_o    = RW_WRITE;
                mem_wdata_o = store_data_i[{cnt_q, 3'b000} +: BYTE_W];
            end else begin
                mem_rw_o = RW_READ;
            end
        end
    end

    assign mem_addr_o = base_addr_i + XLEN'(cnt_q);
    assign done_o     = (state_q == S_DONE);

    // Read data lags the issue by one cycle, so capture trails the counter
    assign bif.clear       = (state_q == S_IDLE) && start_i && !is_store_i;
    assign bif.capture     = !is_store_i &&
                             (((state_q == S_ACCESS) && (cnt_q != '0)) ||
                              (state_q == S_DRAIN));
    assign bif.byte_idx    = cnt_q - BYTE_IDX_W'(1);
    assign bif.width       = last_idx;
    assign bif.is_unsigned = is_unsigned;

endmodule

`default_nettype wire

// File: rtl/mem_stage.sv
// Memory-access stage top that runs byte-serial loads and stores and builds the writeback bundle
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  mem_pkg::opcode_e               opcode_i,
    input  mem_pkg::mem_funct_e            funct_i,
    input  logic                           we_i,
    input  logic [mem_pkg::REG_ADDR_W-1:0] waddr_i,
    input  logic [mem_pkg::XLEN-1:0]       alu_i,
    input  logic [mem_pkg::XLEN-1:0]       store_data_i,
    input  logic [mem_pkg::BYTE_W-1:0]     mem_rdata_i,
    output mem_pkg::opcode_e               opcode_o,
    output logic                           we_o,
    output logic [mem_pkg::REG_ADDR_W-1:0] waddr_o,
    output logic [mem_pkg::XLEN-1:0]       wdata_o,
    output logic                           stall_o,
    output mem_pkg::mem_rw_e               mem_rw_o,
    output logic [mem_pkg::XLEN-1:0]       mem_addr_o,
    output logic [mem_pkg::BYTE_W-1:0]     mem_wdata_o
);
    import mem_pkg::*;

    logic            is_mem;
    logic            is_store;
    logic            done;
    logic [XLEN-1:0] load_data;

    mem_byte_if bif0 ();

    assign is_store = (opcode_i == OP_STORE);
    assign is_mem   = (opcode_i == OP_LOAD) || is_store;

    mem_byte_seq seq0 (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .start_i      (is_mem),
        .is_store_i   (is_store),
        .funct_i      (funct_i),
        .base_addr_i  (alu_i),
        .store_data_i (store_data_i),
        .mem_rw_o     (mem_rw_o),
        .mem_addr_o   (mem_addr_o),
        .mem_wdata_o  (mem_wdata_o),
        .done_o       (done),
        .bif          (bif0.seq)
    );

    load_unit load0 (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .mem_rdata_i (mem_rdata_i),
        .bif         (bif0.load),
        .load_data_o (load_data)
    );

    // Stall until the sequencer reports done
    assign stall_o = is_mem && !done;

    always_comb begin
        if (stall_o) begin
            // NOP bundle while the access runs
            opcode_o = OP_NOP;
            we_o     = 1'b0;
            waddr_o  = '0;
            wdata_o  = '0;
        end else begin
            opcode_o = opcode_i;
            we_o     = we_i;
            waddr_o  = waddr_i;
            if (opcode_i == OP_LOAD) begin
                wdata_o = load_data;
            end else if (is_store) begin
                wdata_o = '0;
            end else begin
                wdata_o = alu_i;
            end
        end
    end

endmodule

`default_nettype wire

// File: verif/mem_stage_asserts.sv
// Protocol assertions for the byte sequencer, attached to every mem_byte_seq instance by bind
`timescale 1ns/1ps
`default_nettype none

module mem_stage_asserts (
    input logic                     clk,
    input logic                     rst_n_i,
    input mem_pkg::seq_state_e      state_i,
    input mem_pkg::mem_rw_e         mem_rw_i,
    input logic [mem_pkg::XLEN-1:0] mem_addr_i,
    input logic                     done_i
);
    import mem_pkg::*;

    int unsigned fail_count = 0;

    // Port only busy while bytes are issued
    rw_idle_outside_access: assert property (@(posedge clk) disable iff (!rst_n_i)
        (state_i != S_ACCESS) |-> (mem_rw_i == RW_IDLE))
    else begin
        $error("Memory port is active outside the access state");
        fail_count++;
    end

    done_single_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
        done_i |=> !done_i)
    else begin
        $error("Done stayed high for more than one cycle");
        fail_count++;
    end

    // One byte per cycle, consecutive addresses
    addr_step_by_one: assert property (@(posedge clk) disable iff (!rst_n_i)
        ((state_i == S_ACCESS) && ($past(state_i) == S_ACCESS))
            |-> (mem_addr_i == $past(mem_addr_i) + 1))
    else begin
        $error("Byte address did not advance by one");
        fail_count++;
    end

endmodule

bind mem_byte_seq mem_stage_asserts asrt0 (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .state_i    (state_q),
    .mem_rw_i   (mem_rw_o),
    .mem_addr_i (mem_addr_o),
    .done_i     (done_o)
);

`default_nettype wire

// File: verif/mem_checker.sv
// Scoreboard that watches the memory stage ports each cycle and compares them with a model
`timescale 1ns/1ps
`default_nettype none

module mem_checker (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  mem_pkg::opcode_e               op_opcode_i,
    input  mem_pkg::mem_funct_e            op_funct_i,
    input  logic                           op_we_i,
    input  logic [mem_pkg::REG_ADDR_W-1:0] op_waddr_i,
    input  logic [mem_pkg::XLEN-1:0]       op_alu_i,
    input  logic [mem_pkg::XLEN-1:0]       op_store_data_i,
    input  mem_pkg::opcode_e               wb_opcode_i,
    input  logic                           wb_we_i,
    input  logic [mem_pkg::REG_ADDR_W-1:0] wb_waddr_i,
    input  logic [mem_pkg::XLEN-1:0]       wb_wdata_i,
    input  logic                           stall_i,
    input  mem_pkg::mem_rw_e               mem_rw_i,
    input  logic [mem_pkg::XLEN-1:0]       mem_addr_i,
    input  logic [mem_pkg::BYTE_W-1:0]     mem_wdata_i,
    output int unsigned                    error_count_o,
    output int unsigned                    check_count_o,
    output int unsigned                    ops_done_o
);
    import mem_pkg::*;

    localparam int REF_BYTES = 256;

    logic [BYTE_W-1:0] ref_mem [REF_BYTES];
    int                op_cycle;
    logic              seen_op;

    // Same fill as the memory model
    initial begin
        for (int a = 0; a < REF_BYTES; a++) begin
            ref_mem[a] = 8'(a * 37) ^ 8'h5a;
        end
        error_count_o = 0;
        check_count_o = 0;
        ops_done_o    = 0;
    end

    task automatic check_value(input string name, input logic [XLEN-1:0] expected,
                               input logic [XLEN-1:0] actual);
        check_count_o++;
        if (actual !== expected) begin
            error_count_o++;
            $display("Fail %s at %0t: expected %h, actual %h", name, $time, expected, actual);
        end
    endtask

    function automatic int byte_count(input mem_funct_e funct);
        case (funct)
            F_B, F_BU: return 1;
            F_H, F_HU: return 2;
            default:   return 4;
        endcase
    endfunction

    function automatic string load_name(input mem_funct_e funct);
        case (funct)
            F_B:     return "lb";
            F_BU:    return "lbu";
            F_H:     return "lh";
            F_HU:    return "lhu";
            default: return "lw";
        endcase
    endfunction

    // Little-endian word from the reference memory, then extension
    function automatic logic [XLEN-1:0] expected_load(input mem_funct_e funct,
                                                      input logic [XLEN-1:0] base);
        logic [7:0] b0;
        logic [7:0] b1;
        logic [7:0] b2;
        logic [7:0] b3;
        b0 = ref_mem[8'(base)];
        b1 = ref_mem[8'(base + 1)];
        b2 = ref_mem[8'(base + 2)];
        b3 = ref_mem[8'(base + 3)];
        case (funct)
            F_B:     return {{24{b0[7]}}, b0};
            F_BU:    return {24'h0, b0};
            F_H:     return {{16{b1[7]}}, b1, b0};
            F_HU:    return {16'h0, b1, b0};
            default: return {b3, b2, b1, b0};
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Per-cycle checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_mem_cycle();
        int         nbytes;
        int         k;
        logic       is_store;
        logic [1:0] port_rw;
        nbytes   = byte_count(op_funct_i);
        is_store = (op_opcode_i == OP_STORE);
        port_rw  = is_store ? RW_WRITE : RW_READ;
        if (op_cycle < nbytes + 2) begin
            check_value("stall_held", 1, stall_i);
            check_value("nop_ctrl", '0, {wb_opcode_i, wb_we_i, wb_waddr_i});
            check_value("nop_wdata", '0, wb_wdata_i);
            if (op_cycle >= 1 && op_cycle <= nbytes) begin
                k = op_cycle - 1;
                check_value("byte_rw", port_rw, mem_rw_i);
                check_value("byte_addr", op_alu_i + k, mem_addr_i);
                if (is_store) begin
                    check_value("store_byte", op_store_data_i[8*k +: 8], mem_wdata_i);
                end
            end else begin
                check_value("port_idle", RW_IDLE, mem_rw_i);
            end
        end else begin
            // Completion cycle
            check_value("stall_release", 0, stall_i);
            check_value("wb_ctrl", {op_opcode_i, op_we_i, op_waddr_i},
                        {wb_opcode_i, wb_we_i, wb_waddr_i});
            check_value("port_idle", RW_IDLE, mem_rw_i);
            if (is_store) begin
                check_value("store_wdata", '0, wb_wdata_i);
                for (k = 0; k < nbytes; k++) begin
                    ref_mem[8'(op_alu_i + k)] = op_store_data_i[8*k +: 8];
                end
            end else begin
                check_value(load_name(op_funct_i), expected_load(op_funct_i, op_alu_i),
                            wb_wdata_i);
            end
            ops_done_o++;
        end
    endtask

    task automatic check_pass_through();
        check_value("alu_stall", 0, stall_i);
        check_value("alu_ctrl", {op_opcode_i, op_we_i, op_waddr_i},
                    {wb_opcode_i, wb_we_i, wb_waddr_i});
        check_value("alu_wdata", op_alu_i, wb_wdata_i);
        check_value("alu_port_idle", RW_IDLE, mem_rw_i);
        if (op_opcode_i != OP_NOP) begin
            ops_done_o++;
        end
    endtask

    always @(negedge clk) begin
        if (!rst_n_i) begin
            op_cycle = 0;
            seen_op  = 1'b0;
        end else begin
            if (op_opcode_i != OP_NOP) begin
                seen_op = 1'b1;
            end
            if (!seen_op) begin
                check_value("reset_idle", {1'b0, 1'b0, RW_IDLE}, {wb_we_i, stall_i, mem_rw_i});
            end
            if (op_opcode_i == OP_LOAD || op_opcode_i == OP_STORE) begin
                check_mem_cycle();
            end else begin
                check_pass_through();
            end
            op_cycle = stall_i ? op_cycle + 1 : 0;
        end
    end

endmodule

`default_nettype wire

// File: verif/tb_mem_stage.sv
// Testbench top that runs random ops through the memory stage against a byte memory model
`timescale 1ns/1ps
`default_nettype none

module tb_mem_stage;
    import mem_pkg::*;

    localparam int NUM_OPS        = 400;
    localparam int TIMEOUT_CYCLES = NUM_OPS * 8 + 100;
    localparam int MEM_BYTES      = 256;

    logic                  clk;
    logic                  rst_n_i;
    opcode_e               opcode_i;
    mem_funct_e            funct_i;
    logic                  we_i;
    logic [REG_ADDR_W-1:0] waddr_i;
    logic [XLEN-1:0]       alu_i;
    logic [XLEN-1:0]       store_data_i;
    logic [BYTE_W-1:0]     mem_rdata_i;
    opcode_e               opcode_o;
    logic                  we_o;
    logic [REG_ADDR_W-1:0] waddr_o;
    logic [XLEN-1:0]       wdata_o;
    logic                  stall_o;
    mem_rw_e               mem_rw_o;
    logic [XLEN-1:0]       mem_addr_o;
    logic [BYTE_W-1:0]     mem_wdata_o;

    logic [BYTE_W-1:0] mem [MEM_BYTES];
    int                seed;
    int                cycle_count;
    int unsigned       error_count;
    int unsigned       check_count;
    int unsigned       ops_done;
    int unsigned       total_errors;

    mem_stage dut0 (.*);

    mem_checker chk0 (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .op_opcode_i     (opcode_i),
        .op_funct_i      (funct_i),
        .op_we_i         (we_i),
        .op_waddr_i      (waddr_i),
        .op_alu_i        (alu_i),
        .op_store_data_i (store_data_i),
        .wb_opcode_i     (opcode_o),
        .wb_we_i         (we_o),
        .wb_waddr_i      (waddr_o),
        .wb_wdata_i      (wdata_o),
        .stall_i         (stall_o),
        .mem_rw_i        (mem_rw_o),
        .mem_addr_i      (mem_addr_o),
        .mem_wdata_i     (mem_wdata_o),
        .error_count_o   (error_count),
        .check_count_o   (check_count),
        .ops_done_o      (ops_done)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Byte memory, read data one cycle after the command
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        mem_rdata_i = '0;
        for (int a = 0; a < MEM_BYTES; a++) begin
            mem[a] = 8'(a * 37) ^ 8'h5a;
        end
    end

    always @(posedge clk) begin
        if (mem_rw_o == RW_WRITE) begin
            mem[mem_addr_o[7:0]] <= mem_wdata_o;
        end else if (mem_rw_o == RW_READ) begin
            mem_rdata_i <= mem[mem_addr_o[7:0]];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    function automatic mem_funct_e pick_funct(input logic [2:0] sel, input logic is_store);
        case (sel)
            3'd0:    return F_B;
            3'd1:    return F_H;
            3'd3:    return is_store ? F_B : F_BU;
            3'd4:    return is_store ? F_H : F_HU;
            default: return F_W;
        endcase
    endfunction

    task automatic drive_random_op();
        logic [31:0] r;
        r = $random(seed);
        we_i         <= r[13];
        waddr_i      <= r[12:8];
        store_data_i <= $random(seed);
        case (r[2:0])
            3'd0, 3'd1: begin
                opcode_i <= r[3] ? OP_REG : OP_IMM;
                funct_i  <= F_B;
                alu_i    <= $random(seed);
            end
            3'd2, 3'd3, 3'd4: begin
                opcode_i <= OP_LOAD;
                funct_i  <= pick_funct(r[6:4], 1'b0);
                alu_i    <= 32'h40 + r[21:16];
            end
            default: begin
                opcode_i <= OP_STORE;
                funct_i  <= pick_funct(r[6:4], 1'b1);
                alu_i    <= 32'h40 + r[21:16];
            end
        endcase
    endtask

    initial begin
        int issued;
        rst_n_i      = 1'b0;
        opcode_i     = OP_NOP;
        funct_i      = F_B;
        we_i         = 1'b0;
        waddr_i      = '0;
        alu_i        = '0;
        store_data_i = '0;
        seed         = 32'h9c5d9467;
        issued       = 0;
        repeat (8) @(posedge clk);
        rst_n_i <= 1'b1;
        // Idle cycles before the first op
        repeat (3) @(posedge clk);
        while (issued < NUM_OPS) begin
            if (!stall_o) begin
                drive_random_op();
                issued++;
            end
            @(posedge clk);
        end
        while (stall_o) begin
            @(posedge clk);
        end
        opcode_i <= OP_NOP;
        we_i     <= 1'b0;
        repeat (2) @(posedge clk);
        total_errors = error_count + dut0.seq0.asrt0.fail_count;
        if (ops_done != NUM_OPS) begin
            $display("Only %0d of %0d ops completed", ops_done, NUM_OPS);
            total_errors++;
        end
        $display("Summary: %0d checks, %0d check errors, %0d assertion failures",
                 check_count, error_count, dut0.seq0.asrt0.fail_count);
        if (total_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: mem_stage.f
rtl/mem_pkg.sv
rtl/mem_byte_if.sv
rtl/load_unit.sv
rtl/mem_byte_seq.sv
rtl/mem_stage.sv
verif/mem_stage_asserts.sv
verif/mem_checker.sv
verif/tb_mem_stage.sv

// File: Bender.yml
package:
  name: mem_stage

sources:
  - rtl/mem_pkg.sv
  - rtl/mem_byte_if.sv
  - rtl/load_unit.sv
  - rtl/mem_byte_seq.sv
  - rtl/mem_stage.sv
  - target: test
    files:
      - verif/mem_stage_asserts.sv
      - verif/mem_checker.sv
      - verif/tb_mem_stage.sv
